// ==== l1dCache_defines.svh ====
`ifndef L1D_CACHE_DEFINES_SVH
`define L1D_CACHE_DEFINES_SVH

// 1 selects the 16-entry bank build
`define L1D_SMALL 0

// index bits per bank, from tile address bit 1 upward
`define L1D_IX_BITS ((`L1D_SMALL) ? 4 : 6)

`define L1D_TILE_BITS 128
`define L1D_TILE_ADDR_BITS 28 // 32-bit address minus the 16-byte offset

// uncached region, top address nibble
`define L1D_MMIO_NIBBLE 4'hA

// start of the backing memory image
`define L1D_MEM_BASE 32'h0000_0000

`endif

// ==== l1dCachePkg.sv ====
`include "l1dCache_defines.svh"

package l1dCachePkg;

	typedef logic [4:0] opm_t; // [4:3] class, [2] zero-extend, [1:0] size
	typedef logic [4:0] memOpm_t;
	typedef logic [1:0] status_t;
	typedef logic [63:0] word_t;
	typedef logic [`L1D_TILE_BITS-1:0] tile_t;
	typedef logic [`L1D_TILE_ADDR_BITS-1:0] tileAddr_t;
	typedef logic [`L1D_IX_BITS-1:0] tileIx_t;

	localparam logic [1:0] OPC_NONE = 2'b00;
	localparam logic [1:0] OPC_LOAD = 2'b01;
	localparam logic [1:0] OPC_STORE = 2'b10;

	// tile ops use class 11, which no core opcode has
	localparam memOpm_t OPM_READY = 5'b00000;
	localparam memOpm_t OPM_RD_TILE = 5'b11011;
	localparam memOpm_t OPM_WR_TILE = 5'b11111;

	localparam status_t ST_READY = 2'b00;
	localparam status_t ST_OK = 2'b01;
	localparam status_t ST_HOLD = 2'b10;

	typedef struct packed {
		tileAddr_t addr;
		logic spare; // always written zero
		logic dirty;
		logic [1:0] check; // ~addr[1:0] when valid
	} tileTag_t;

	typedef struct packed {
		tileTag_t tag;
		tile_t data;
	} tileEntry_t;

	typedef struct packed {
		logic [31:0] addr;
		opm_t opm;
		word_t data;
	} coreReq_t;

	typedef struct packed {
		coreReq_t req;
		tileAddr_t addrEven;
		tileAddr_t addrOdd;
		tileIx_t ixEven;
		tileIx_t ixOdd;
		logic isMmio;
	} stageReq_t;

	typedef struct packed {
		logic en;
		tileIx_t ix;
		tileEntry_t entry;
	} bankWrite_t;

	typedef struct packed {
		logic [31:0] addr;
		memOpm_t opm;
		tile_t data;
	} memReq_t;

	typedef struct packed {
		logic missEven;
		logic missOdd;
		logic isMmio; // pending uncached access
		coreReq_t req;
		tileAddr_t addrEven;
		tileAddr_t addrOdd;
		tileIx_t ixEven;
		tileIx_t ixOdd;
		tileEntry_t victimEven;
		tileEntry_t victimOdd;
	} missReq_t;

endpackage

// ==== l1dAddrStage.sv ====
`timescale 1ns/100ps
`include "l1dCache_defines.svh"

module l1dAddrStage (
	input  logic                   clock,
	input  logic                   reset,
	input  l1dCachePkg::coreReq_t  req,
	input  logic                   stall,
	output l1dCachePkg::stageReq_t stageOut,
	output l1dCachePkg::tileIx_t   nextIxEven,
	output l1dCachePkg::tileIx_t   nextIxOdd
);
	import l1dCachePkg::*;

	stageReq_t next;
	tileAddr_t tileLo;
	tileAddr_t tileHi;

	always_comb
	begin
		tileLo = req.addr[31:4];
		tileHi = tileLo + 1'b1;
		next.req = req;
		if (req.addr[4]) // first tile sits in the odd bank
		begin
			next.addrOdd = tileLo;
			next.addrEven = tileHi;
		end
		else
		begin
			next.addrEven = tileLo;
			next.addrOdd = tileHi;
		end
		next.ixEven = next.addrEven[`L1D_IX_BITS:1];
		next.ixOdd = next.addrOdd[`L1D_IX_BITS:1];
		next.isMmio = (req.addr[31:28] == `L1D_MMIO_NIBBLE);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			stageOut.req.opm <= {OPC_NONE, 3'b000};
		else if (!stall)
			stageOut <= next;
	end

	// held request keeps re-reading its own tiles
	assign nextIxEven = stall ? stageOut.ixEven : next.ixEven;
	assign nextIxOdd = stall ? stageOut.ixOdd : next.ixOdd;

endmodule

// ==== l1dTileBank.sv ====
`timescale 1ns/100ps

module l1dTileBank (
	input  logic                    clock,
	input  logic                    reset,
	input  l1dCachePkg::tileIx_t    readIx,
	output l1dCachePkg::tileEntry_t readEntry,
	input  l1dCachePkg::bankWrite_t write,
	output logic                    initBusy
);
	import l1dCachePkg::*;

	localparam int Depth = 1 << $bits(tileIx_t);

	tileEntry_t mem [0:Depth-1];
	tileIx_t initIx;
	bankWrite_t wr;

	always_comb
	begin
		wr = write;
		if (initBusy) // all-zero tag fails the check field
		begin
			wr.en = 1'b1;
			wr.ix = initIx;
			wr.entry = '0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wr.en)
			mem[wr.ix] <= wr.entry;
		readEntry <= (wr.en && wr.ix == readIx) ? wr.entry : mem[readIx]; // write-first
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			initIx <= '0;
			initBusy <= 1'b1;
		end
		else if (initBusy)
		begin
			initIx <= initIx + 1'b1;
			if (&initIx)
				initBusy <= 1'b0;
		end
	end

endmodule

// ==== l1dAccessStage.sv ====
`timescale 1ns/100ps

module l1dAccessStage (
	input  logic                    clock,
	input  logic                    reset,
	input  l1dCachePkg::stageReq_t  stageIn,
	input  l1dCachePkg::tileEntry_t entryEven,
	input  l1dCachePkg::tileEntry_t entryOdd,
	input  logic                    fillBusy,
	input  logic                    mmioDone,
	input  l1dCachePkg::word_t      mmioData,
	output l1dCachePkg::bankWrite_t writeEven,
	output l1dCachePkg::bankWrite_t writeOdd,
	output l1dCachePkg::missReq_t   miss,
	output l1dCachePkg::word_t      loadVal,
	output l1dCachePkg::status_t    status,
	output logic                    stall
);
	import l1dCachePkg::*;

	bankWrite_t lastEven;
	bankWrite_t lastOdd;
	tileEntry_t curEven;
	tileEntry_t curOdd;
	logic reqValid;
	logic isStore;
	logic zeroExt;
	logic hitEven;
	logic hitOdd;
	logic [5:0] bitOfs;
	tile_t win;
	tile_t winW;
	tile_t mask;
	tile_t newEven;
	tile_t newOdd;
	word_t ext;
	word_t loadExt;
	word_t sizeMask;

	always_comb
	begin
		curEven = (lastEven.en && lastEven.ix == stageIn.ixEven) ? lastEven.entry : entryEven;
		curOdd = (lastOdd.en && lastOdd.ix == stageIn.ixOdd) ? lastOdd.entry : entryOdd;
		reqValid = (stageIn.req.opm[4:3] == OPC_LOAD) || (stageIn.req.opm[4:3] == OPC_STORE);
		isStore = stageIn.req.opm[4:3] == OPC_STORE;
		zeroExt = stageIn.req.opm[2];
		hitEven = (curEven.tag.addr == stageIn.addrEven) &&
			(curEven.tag.check == ~curEven.tag.addr[1:0]);
		hitOdd = (curOdd.tag.addr == stageIn.addrOdd) &&
			(curOdd.tag.check == ~curOdd.tag.addr[1:0]);

		// 16-byte window starting at the addressed 8-byte word
		case (stageIn.req.addr[4:3])
			2'b00: win = curEven.data;
			2'b01: win = {curOdd.data[63:0], curEven.data[127:64]};
			2'b10: win = curOdd.data;
			default: win = {curEven.data[63:0], curOdd.data[127:64]};
		endcase
		bitOfs = {stageIn.req.addr[2:0], 3'b000};
		ext = word_t'(win >> bitOfs);

		case (stageIn.req.opm[1:0])
			2'd0: loadExt = {{56{ext[7] & ~zeroExt}}, ext[7:0]};
			2'd1: loadExt = {{48{ext[15] & ~zeroExt}}, ext[15:0]};
			2'd2: loadExt = {{32{ext[31] & ~zeroExt}}, ext[31:0]};
			default: loadExt = ext;
		endcase
		loadVal = stageIn.isMmio ? mmioData : loadExt;

		case (stageIn.req.opm[1:0])
			2'd0: sizeMask = 64'h0000_0000_0000_00FF;
			2'd1: sizeMask = 64'h0000_0000_0000_FFFF;
			2'd2: sizeMask = 64'h0000_0000_FFFF_FFFF;
			default: sizeMask = '1;
		endcase
		mask = tile_t'(sizeMask) << bitOfs;
		winW = (win & ~mask) | (tile_t'(stageIn.req.data & sizeMask) << bitOfs);

		// undo the rotation for each bank
		newEven = curEven.data;
		newOdd = curOdd.data;
		case (stageIn.req.addr[4:3])
			2'b00: newEven = winW;
			2'b01:
			begin
				newEven = {winW[63:0], curEven.data[63:0]};
				newOdd = {curOdd.data[127:64], winW[127:64]};
			end
			2'b10: newOdd = winW;
			default:
			begin
				newOdd = {winW[63:0], curOdd.data[63:0]};
				newEven = {curEven.data[127:64], winW[127:64]};
			end
		endcase

		miss.missEven = reqValid && !stageIn.isMmio && !hitEven;
		miss.missOdd = reqValid && !stageIn.isMmio && !hitOdd;
		miss.isMmio = reqValid && stageIn.isMmio;
		miss.req = stageIn.req;
		miss.addrEven = stageIn.addrEven;
		miss.addrOdd = stageIn.addrOdd;
		miss.ixEven = stageIn.ixEven;
		miss.ixOdd = stageIn.ixOdd;
		miss.victimEven = curEven;
		miss.victimOdd = curOdd;

		if (stageIn.isMmio)
			stall = reqValid && !mmioDone;
		else
			stall = reqValid && (miss.missEven || miss.missOdd || fillBusy);
		status = stall ? ST_HOLD : (reqValid ? ST_OK : ST_READY);

		writeEven.en = isStore && !stageIn.isMmio && !stall && (stageIn.req.addr[4:3] != 2'b10);
		writeEven.ix = stageIn.ixEven;
		writeEven.entry.tag = '{addr: stageIn.addrEven, spare: 1'b0, dirty: 1'b1,
			check: ~stageIn.addrEven[1:0]};
		writeEven.entry.data = newEven;
		writeOdd.en = isStore && !stageIn.isMmio && !stall && (stageIn.req.addr[4:3] != 2'b00);
		writeOdd.ix = stageIn.ixOdd;
		writeOdd.entry.tag = '{addr: stageIn.addrOdd, spare: 1'b0, dirty: 1'b1,
			check: ~stageIn.addrOdd[1:0]};
		writeOdd.entry.data = newOdd;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lastEven.en <= 1'b0;
			lastOdd.en <= 1'b0;
		end
		else
		begin
			lastEven <= writeEven;
			lastOdd <= writeOdd;
		end
	end

endmodule

// ==== l1dMissEngine.sv ====
`timescale 1ns/100ps

module l1dMissEngine (
	input  logic                    clock,
	input  logic                    reset,
	input  l1dCachePkg::missReq_t   miss,
	input  l1dCachePkg::tile_t      memDataIn,
	input  l1dCachePkg::status_t    memOk,
	output l1dCachePkg::memReq_t    memReq,
	output l1dCachePkg::bankWrite_t fillEven,
	output l1dCachePkg::bankWrite_t fillOdd,
	output logic                    fillBusy,
	output logic                    mmioDone,
	output l1dCachePkg::word_t      mmioData
);
	import l1dCachePkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WB,
		S_RDW,
		S_RD,
		S_FILL,
		S_MMIO,
		S_MMIODONE
	} state_t;

	state_t state;
	logic selOdd;
	tileAddr_t tileAddr;
	tileIx_t tileIx;
	bankWrite_t fillQ;
	logic pickOdd;
	tileAddr_t pickAddr;
	tileIx_t pickIx;
	tileEntry_t victim;
	logic victimDirty;

	always_comb
	begin
		pickOdd = !miss.missEven; // even bank goes first
		pickAddr = pickOdd ? miss.addrOdd : miss.addrEven;
		pickIx = pickOdd ? miss.ixOdd : miss.ixEven;
		victim = pickOdd ? miss.victimOdd : miss.victimEven;
		victimDirty = victim.tag.dirty && (victim.tag.check == ~victim.tag.addr[1:0]);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			memReq.opm <= OPM_READY;
			fillQ.en <= 1'b0;
			mmioDone <= 1'b0;
		end
		else
		begin
			fillQ.en <= 1'b0;
			mmioDone <= 1'b0;
			case (state)
				S_IDLE:
					if (memOk == ST_READY)
					begin
						if (miss.isMmio)
						begin
							memReq <= '{addr: miss.req.addr, opm: miss.req.opm,
								data: {64'b0, miss.req.data}};
							state <= S_MMIO;
						end
						else if (miss.missEven || miss.missOdd)
						begin
							selOdd <= pickOdd;
							tileAddr <= pickAddr;
							tileIx <= pickIx;
							if (victimDirty)
							begin
								memReq <= '{addr: {victim.tag.addr, 4'b0000}, opm: OPM_WR_TILE,
									data: victim.data};
								state <= S_WB;
							end
							else
							begin
								memReq <= '{addr: {pickAddr, 4'b0000}, opm: OPM_RD_TILE, data: '0};
								state <= S_RD;
							end
						end
					end
				S_WB:
					if (memOk == ST_OK)
					begin
						memReq.opm <= OPM_READY;
						state <= S_RDW;
					end
				S_RDW: // memory must drop back to ready first
					if (memOk == ST_READY)
					begin
						memReq <= '{addr: {tileAddr, 4'b0000}, opm: OPM_RD_TILE, data: '0};
						state <= S_RD;
					end
				S_RD:
					if (memOk == ST_OK)
					begin
						memReq.opm <= OPM_READY;
						fillQ.en <= 1'b1;
						fillQ.ix <= tileIx;
						fillQ.entry <= '{tag: '{addr: tileAddr, spare: 1'b0, dirty: 1'b0,
							check: ~tileAddr[1:0]}, data: memDataIn};
						state <= S_FILL;
					end
				S_FILL:
					state <= S_IDLE; // bank takes the tile at this edge
				S_MMIO:
					if (memOk == ST_OK)
					begin
						memReq.opm <= OPM_READY;
						mmioData <= memDataIn[63:0];
						mmioDone <= 1'b1;
						state <= S_MMIODONE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_comb
	begin
		fillEven = fillQ;
		fillOdd = fillQ;
		fillEven.en = fillQ.en && !selOdd;
		fillOdd.en = fillQ.en && selOdd;
	end

	assign fillBusy = (state == S_WB) || (state == S_RDW) || (state == S_RD) ||
		(state == S_FILL);

endmodule

// ==== l1dCache.sv ====
`timescale 1ns/100ps

module l1dCache (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [31:0]          reqAddr,
	input  l1dCachePkg::opm_t    reqOpm,
	input  l1dCachePkg::word_t   reqData,
	output l1dCachePkg::word_t   loadVal,
	output l1dCachePkg::status_t status,
	output l1dCachePkg::memReq_t memReq,
	input  l1dCachePkg::tile_t   memDataIn,
	input  l1dCachePkg::status_t memOk
);
	import l1dCachePkg::*;

	coreReq_t req;
	stageReq_t stageReq;
	tileIx_t nextIxEven;
	tileIx_t nextIxOdd;
	tileEntry_t entryEven;
	tileEntry_t entryOdd;
	bankWrite_t storeEven;
	bankWrite_t storeOdd;
	bankWrite_t fillEven;
	bankWrite_t fillOdd;
	bankWrite_t bankWrEven;
	bankWrite_t bankWrOdd;
	missReq_t miss;
	logic stall;
	logic engineBusy;
	logic initBusyEven;
	logic initBusyOdd;
	logic fillBusy;
	logic mmioDone;
	word_t mmioData;

	assign req = '{addr: reqAddr, opm: reqOpm, data: reqData};
	assign fillBusy = engineBusy | initBusyEven | initBusyOdd; // init walk holds too
	assign bankWrEven = fillEven.en ? fillEven : storeEven;
	assign bankWrOdd = fillOdd.en ? fillOdd : storeOdd;

	l1dAddrStage addrStage_inst (
		.clock(clock), .reset(reset), .req(req), .stall(stall),
		.stageOut(stageReq), .nextIxEven(nextIxEven), .nextIxOdd(nextIxOdd));

	l1dTileBank bankEven_inst (
		.clock(clock), .reset(reset), .readIx(nextIxEven), .readEntry(entryEven),
		.write(bankWrEven), .initBusy(initBusyEven));

	l1dTileBank bankOdd_inst (
		.clock(clock), .reset(reset), .readIx(nextIxOdd), .readEntry(entryOdd),
		.write(bankWrOdd), .initBusy(initBusyOdd));

	l1dAccessStage accessStage_inst (
		.clock(clock), .reset(reset), .stageIn(stageReq),
		.entryEven(entryEven), .entryOdd(entryOdd), .fillBusy(fillBusy),
		.mmioDone(mmioDone), .mmioData(mmioData),
		.writeEven(storeEven), .writeOdd(storeOdd), .miss(miss),
		.loadVal(loadVal), .status(status), .stall(stall));

	l1dMissEngine missEngine_inst (
		.clock(clock), .reset(reset), .miss(miss), .memDataIn(memDataIn), .memOk(memOk),
		.memReq(memReq), .fillEven(fillEven), .fillOdd(fillOdd), .fillBusy(engineBusy),
		.mmioDone(mmioDone), .mmioData(mmioData));

endmodule

// ==== l1dMemModel.sv ====
`timescale 1ns/100ps

module l1dMemModel (
	input  logic                 clock,
	input  logic                 reset,
	input  l1dCachePkg::memReq_t memReq,
	output l1dCachePkg::tile_t   memDataIn,
	output l1dCachePkg::status_t memOk
);
	import l1dCachePkg::*;

	logic [7:0] mem [0:8191]; // 8 KB image, address bits 12..0
	word_t mmioReg;
	integer seed;
	int draw;
	int waitCnt;
	logic busy;
	int tileOps;
	int mmioOps;

	function automatic logic [7:0] imageByte(input logic [31:0] a);
		return 8'(a * 7 + (~a >> 8));
	endfunction

	initial
	begin
		seed = 32'h9882_5906;
		tileOps = 0;
		mmioOps = 0;
		mmioReg = 64'h0123_4567_89AB_CDEF;
		for (int i = 0; i < 8192; i++)
			mem[i] = imageByte(i);
	end

	// one transfer, answered with ST_OK
	task automatic serve;
		logic [12:0] base;
		base = {memReq.addr[12:4], 4'b0000};
		if (memReq.opm == OPM_RD_TILE)
		begin
			for (int k = 0; k < 16; k++)
				memDataIn[8*k +: 8] <= mem[base + 13'(k)];
			tileOps <= tileOps + 1;
		end
		else if (memReq.opm == OPM_WR_TILE)
		begin
			for (int k = 0; k < 16; k++)
				mem[base + 13'(k)] = memReq.data[8*k +: 8];
			tileOps <= tileOps + 1;
		end
		else
		begin
			if (memReq.opm[4:3] == OPC_STORE) // uncached pass-through
				mmioReg <= memReq.data[63:0];
			else
				memDataIn <= {64'b0, mmioReg};
			mmioOps <= mmioOps + 1;
		end
		memOk <= ST_OK;
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			memOk <= ST_READY;
			busy <= 1'b0;
			memDataIn <= '0;
		end
		else if (memOk == ST_OK)
			memOk <= ST_READY;
		else if (busy)
		begin
			if (waitCnt == 0)
			begin
				serve();
				busy <= 1'b0;
			end
			else
				waitCnt <= waitCnt - 1;
		end
		else if (memReq.opm != OPM_READY)
		begin
			draw = $unsigned($random(seed)) % 4; // 0 to 3 hold cycles
			if (draw == 0)
				serve();
			else
			begin
				busy <= 1'b1;
				waitCnt <= draw - 1;
				memOk <= ST_HOLD;
			end
		end
	end

endmodule

// ==== l1dCache_chk.sv ====
`timescale 1ns/100ps

module l1dCacheChk (
	input logic                 clock,
	input logic                 reset,
	input l1dCachePkg::memReq_t memReq,
	input l1dCachePkg::status_t memOk,
	input l1dCachePkg::status_t status
);
	import l1dCachePkg::*;

	int failCount = 0;

	holdKeepsRequest: assert property (@(posedge clock) disable iff (reset)
		memOk == ST_HOLD |=> $stable(memReq))
		else begin $error("memory request changed while the memory held"); failCount++; end

	okReleasesRequest: assert property (@(posedge clock) disable iff (reset)
		memOk == ST_OK |=> memReq.opm == OPM_READY)
		else begin $error("memory request not released after ST_OK"); failCount++; end

	startsFromReady: assert property (@(posedge clock) disable iff (reset)
		(memReq.opm != OPM_READY && $past(memReq.opm) == OPM_READY) |->
		$past(memOk) == ST_READY)
		else begin $error("transfer started while memory not ready"); failCount++; end

	holdDuringTransfer: assert property (@(posedge clock) disable iff (reset)
		memReq.opm != OPM_READY |-> status == ST_HOLD)
		else begin $error("core status not held during a memory transfer"); failCount++; end

endmodule

bind l1dCache l1dCacheChk chk_inst (
	.clock(clock), .reset(reset), .memReq(memReq), .memOk(memOk), .status(status));

// ==== l1dCache_tb.sv ====
`timescale 1ns/100ps
`include "l1dCache_defines.svh"

module l1dCacheTb;
	import l1dCachePkg::*;

	typedef struct packed {
		opm_t opm;
		logic [31:0] addr;
		word_t data;
		logic [2:0] src;
		logic noTile; // uncached row, no tile traffic allowed
	} row_t;

	localparam logic [2:0] SRC_NONE = 3'd0;
	localparam logic [2:0] SRC_MEM = 3'd1;
	localparam logic [2:0] SRC_HIT = 3'd2; // must finish without hold
	localparam logic [2:0] SRC_EVICT = 3'd3; // needs a dirty writeback first
	localparam logic [2:0] SRC_MMIO = 3'd4;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] reqAddr;
	opm_t reqOpm;
	word_t reqData;
	word_t loadVal;
	status_t status;
	memReq_t memReq;
	tile_t memDataIn;
	status_t memOk;

	row_t rows[$];
	logic [7:0] shadow [0:8191];
	word_t mmioExpect;
	int cycles = 0;
	int timeoutCycles = 100000;
	int wbCount = 0;
	memOpm_t lastMemOpm = OPM_READY;

	always #4 clock = ~clock;

	l1dCache l1dCache_inst (
		.clock(clock), .reset(reset), .reqAddr(reqAddr), .reqOpm(reqOpm), .reqData(reqData),
		.loadVal(loadVal), .status(status), .memReq(memReq), .memDataIn(memDataIn),
		.memOk(memOk));

	l1dMemModel memModel_inst (
		.clock(clock), .reset(reset), .memReq(memReq), .memDataIn(memDataIn), .memOk(memOk));

	task automatic failRun;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkLoad(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s load %h, expected %h", $time, what, got, exp);
			failRun();
		end
	endtask

	task automatic checkTile(input tile_t got, input tile_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s tile %h, expected %h", $time, what, got, exp);
			failRun();
		end
	endtask

	task automatic checkStatus(input status_t got, input status_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s status %0d, expected %0d", $time, what, got, exp);
			failRun();
		end
	endtask

	task automatic checkMemOpm(input memOpm_t got, input memOpm_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s memory opcode %b, expected %b", $time, what, got, exp);
			failRun();
		end
	endtask

	function automatic logic [7:0] imageByte(input logic [31:0] a);
		return 8'(a * 7 + (~a >> 8));
	endfunction

	function automatic opm_t loadOp(input logic [1:0] size, input logic zext);
		return {OPC_LOAD, zext, size};
	endfunction

	function automatic opm_t storeOp(input logic [1:0] size);
		return {OPC_STORE, 1'b0, size};
	endfunction

	function automatic word_t expectedLoad(input logic [31:0] addr, input opm_t opm);
		int nBytes;
		word_t v;
		logic sign;
		nBytes = 1 << opm[1:0];
		v = '0;
		for (int k = 0; k < nBytes; k++)
			v[8*k +: 8] = shadow[13'(addr + k)];
		sign = v[8*nBytes-1] & ~opm[2];
		for (int b = 8*nBytes; b < 64; b++)
			v[b] = sign;
		return v;
	endfunction

	function automatic tile_t tileAt(input logic [31:0] addr);
		tile_t t;
		for (int k = 0; k < 16; k++)
			t[8*k +: 8] = shadow[{addr[12:4], 4'b0000} + 13'(k)];
		return t;
	endfunction

	task automatic applyStore(input logic [31:0] addr, input opm_t opm, input word_t data);
		int nBytes;
		nBytes = 1 << opm[1:0];
		for (int k = 0; k < nBytes; k++)
			shadow[13'(addr + k)] = data[8*k +: 8];
	endtask

	task automatic addRow(input opm_t opm, input logic [31:0] addr, input word_t data,
		input logic [2:0] src, input logic noTile);
		rows.push_back('{opm: opm, addr: addr, data: data, src: src, noTile: noTile});
	endtask

	task automatic buildTable;
		// every size and offset, tile crossings included
		addRow(loadOp(0, 0), 32'h200, '0, SRC_MEM, 0);
		addRow(loadOp(0, 1), 32'h201, '0, SRC_MEM, 0);
		addRow(loadOp(1, 0), 32'h212, '0, SRC_MEM, 0);
		addRow(loadOp(1, 1), 32'h203, '0, SRC_MEM, 0);
		addRow(loadOp(2, 0), 32'h204, '0, SRC_MEM, 0);
		addRow(loadOp(2, 1), 32'h205, '0, SRC_MEM, 0);
		addRow(loadOp(3, 0), 32'h206, '0, SRC_MEM, 0);
		addRow(loadOp(3, 1), 32'h207, '0, SRC_MEM, 0);
		addRow(loadOp(1, 0), 32'h20F, '0, SRC_MEM, 0);
		addRow(loadOp(2, 0), 32'h20D, '0, SRC_MEM, 0);
		addRow(loadOp(3, 0), 32'h20B, '0, SRC_MEM, 0);
		addRow(loadOp(3, 0), 32'h21A, '0, SRC_MEM, 0); // odd tile into even
		addRow(loadOp(0, 1), 32'h21F, '0, SRC_MEM, 0);
		addRow(loadOp(1, 1), 32'h21E, '0, SRC_HIT, 0);
		// store then load, forwarded
		addRow(storeOp(3), 32'h305, 64'h8123_4567_89AB_CDEF, SRC_NONE, 0);
		addRow(loadOp(3, 0), 32'h305, '0, SRC_HIT, 0);
		addRow(loadOp(0, 1), 32'h304, '0, SRC_HIT, 0);
		addRow(loadOp(0, 0), 32'h30D, '0, SRC_HIT, 0);
		addRow(storeOp(1), 32'h31F, 64'h0000_0000_0000_BEEF, SRC_NONE, 0);
		addRow(loadOp(1, 1), 32'h31F, '0, SRC_HIT, 0);
		addRow(loadOp(2, 0), 32'h31D, '0, SRC_HIT, 0);
		addRow(storeOp(0), 32'h300, 64'h0000_0000_0000_0080, SRC_NONE, 0);
		addRow(loadOp(0, 0), 32'h300, '0, SRC_HIT, 0);
		// dirty victim at the same index
		addRow(storeOp(3), 32'h100, 64'hFEED_FACE_CAFE_F00D, SRC_NONE, 0);
		addRow(loadOp(3, 0), 32'h900, '0, SRC_EVICT, 0);
		addRow(loadOp(3, 0), 32'h100, '0, SRC_MEM, 0);
		addRow(loadOp(2, 1), 32'h104, '0, SRC_HIT, 0);
		// uncached pass-through
		addRow(storeOp(3), {`L1D_MMIO_NIBBLE, 28'h000_0010}, 64'h1357_9BDF_2468_ACE0,
			SRC_NONE, 1);
		addRow(loadOp(3, 0), {`L1D_MMIO_NIBBLE, 28'h000_0010}, '0, SRC_MMIO, 1);
		// back-to-back hits
		addRow(loadOp(3, 0), 32'h300, '0, SRC_HIT, 0);
		addRow(loadOp(3, 0), 32'h308, '0, SRC_HIT, 0);
		addRow(loadOp(3, 0), 32'h310, '0, SRC_HIT, 0);
		addRow(loadOp(2, 0), 32'h318, '0, SRC_HIT, 0);
		addRow(loadOp(3, 0), 32'h100, '0, SRC_HIT, 0);
	endtask

	task automatic driveRow(input row_t r);
		reqAddr <= r.addr;
		reqOpm <= r.opm;
		reqData <= r.data;
	endtask

	// writebacks must carry the merged tile
	always @(negedge clock)
	begin
		if (!reset && memReq.opm == OPM_WR_TILE && lastMemOpm != OPM_WR_TILE)
		begin
			wbCount++;
			checkTile(memReq.data, tileAt(memReq.addr), "writeback");
		end
		lastMemOpm = memReq.opm;
		if (l1dCache_inst.chk_inst.failCount != 0)
		begin
			$display("a bound assertion on the cache ports failed");
			failRun();
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= timeoutCycles)
		begin
			$display("timeout after %0d cycles, the cache never completed a request", cycles);
			failRun();
		end
	end

	initial
	begin
		row_t r;
		string what;
		int holds;
		int wbBefore;
		int tileBefore;
		int mmioBefore;
		reset = 1'b1;
		reqAddr = '0;
		reqOpm = '0;
		reqData = '0;
		mmioExpect = '0;
		for (int i = 0; i < 8192; i++)
			shadow[i] = imageByte(i);
		buildTable();
		timeoutCycles = rows.size() * 40;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkStatus(status, ST_READY, "after reset");
		checkMemOpm(memReq.opm, OPM_READY, "after reset");
		@(posedge clock);
		driveRow(rows[0]);
		for (int i = 0; i < rows.size(); i++)
		begin
			r = rows[i];
			what = $sformatf("row %0d", i);
			@(posedge clock); // row i enters stage B here
			if (i + 1 < rows.size())
				driveRow(rows[i + 1]);
			else
				driveRow('0);
			wbBefore = wbCount;
			tileBefore = memModel_inst.tileOps;
			mmioBefore = memModel_inst.mmioOps;
			holds = 0;
			@(negedge clock);
			while (status == ST_HOLD)
			begin
				holds++;
				@(negedge clock);
			end
			checkStatus(status, ST_OK, what);
			if (r.src == SRC_HIT && holds != 0)
			begin
				$display("%s should hit but held for %0d cycles", what, holds);
				failRun();
			end
			if (r.src == SRC_EVICT && wbCount == wbBefore)
			begin
				$display("%s finished without writing back the dirty victim", what);
				failRun();
			end
			if (r.noTile && (memModel_inst.tileOps != tileBefore ||
				memModel_inst.mmioOps != mmioBefore + 1))
			begin
				$display("%s was not exactly one uncached transfer", what);
				failRun();
			end
			if (r.src == SRC_MMIO)
				checkLoad(loadVal, mmioExpect, what);
			else if (r.src != SRC_NONE)
				checkLoad(loadVal, expectedLoad(r.addr, r.opm), what);
			else if (r.noTile)
				mmioExpect = r.data;
			else
				applyStore(r.addr, r.opm, r.data);
		end
		@(posedge clock);
		@(negedge clock);
		checkStatus(status, ST_READY, "idle at end");
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== l1dCache.f ====
+incdir+.
l1dCachePkg.sv
l1dAddrStage.sv
l1dTileBank.sv
l1dAccessStage.sv
l1dMissEngine.sv
l1dCache.sv
l1dMemModel.sv
l1dCache_chk.sv
l1dCache_tb.sv

// ==== Makefile ====
TOOL   = verilator
TOP    = l1dCacheTb
FLIST  = l1dCache.f
OBJDIR = obj_dir
FLAGS  = --binary --timing --assert -Wno-fatal -Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
